// ==== common/cdc_fifo_pkg.sv ====
/*
 * Shared defaults for the dual-clock FIFO, the synchronizer depth,
 * and the binary to Gray and Gray to binary conversion functions
 */

package cdc_fifo_pkg;

  // Default geometry, overridden through the top level parameters
  localparam int DEFAULT_DEPTH      = 8;
  localparam int DEFAULT_DATA_WIDTH = 16;

  // Flip-flops in each Gray count synchronizer chain
  localparam int SYNC_STAGES = 2;

  // Adjacent binary values map to Gray codes that differ in exactly one bit
  function automatic logic [15:0] bin_to_gray(input logic [15:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above its position
  function automatic logic [15:0] gray_to_bin(input logic [15:0] gray);
    logic [15:0] bin;
    bin[15] = gray[15];
    for (int i = 14; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== logic/gray_count_sync.sv ====
/*
 * Multi-stage synchronizer that carries a Gray-coded count
 * into the clock domain of clk
 */

`timescale 1ns/1ps

module gray_count_sync #(
  parameter int CountWidth = 4
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [CountWidth-1:0] count_gray,
  output logic [CountWidth-1:0] count_gray_sync
);

  // Stage 0 samples the foreign domain, the last stage feeds local logic
  logic [CountWidth-1:0] sync_q [cdc_fifo_pkg::SYNC_STAGES];

  // Only one bit of the Gray count moves per step, so a metastable
  // sample resolves to either the old count or the new one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= count_gray;
      for (int i = 1; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign count_gray_sync = sync_q[cdc_fifo_pkg::SYNC_STAGES-1];

endmodule

// ==== push_side/cdc_fifo_push_flag_mgr.sv ====
/*
 * Push-side flag manager: beat handshake, binary push count,
 * write address, registered Gray push count, and slots and full
 */

`timescale 1ns/1ps

module cdc_fifo_push_flag_mgr #(
  parameter int Depth      = 8,
  parameter int CountWidth = 4
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  push_valid,
  output logic                  push_ready,
  input  logic [CountWidth-1:0] pop_count_gray_sync,
  output logic [CountWidth-1:0] push_count_gray,
  output logic                  wr_en,
  output logic [CountWidth-2:0] wr_addr,
  output logic [CountWidth-1:0] push_slots
);

  localparam int AddrWidth = $clog2(Depth);

  logic                  push_beat;
  logic                  full;
  logic [CountWidth-1:0] push_count;
  logic [CountWidth-1:0] push_count_next;
  logic [CountWidth-1:0] pop_count;
  logic [CountWidth-1:0] items;

  // A beat is taken when the source offers a word and a slot is free
  assign push_beat = push_valid & push_ready;

  // The storage is written on the same edge that takes the beat
  assign wr_en = push_beat;

  // Counts run one bit past the address so a full FIFO differs from an empty one
  assign push_count_next = push_count + CountWidth'(push_beat);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_count <= '0;
    end else begin
      push_count <= push_count_next;
    end
  end

  // The Gray form is taken from the next count so it moves on the beat edge
  // together with the binary count, and it leaves this domain from a flop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_count_gray <= '0;
    end else begin
      push_count_gray <= CountWidth'(cdc_fifo_pkg::bin_to_gray(16'(push_count_next)));
    end
  end

  // Depth is a power of two, so the low count bits wrap exactly at Depth
  assign wr_addr = push_count[AddrWidth-1:0];

  // Decode the pop count seen through the synchronizer
  assign pop_count = CountWidth'(cdc_fifo_pkg::gray_to_bin(16'(pop_count_gray_sync)));

  // Subtraction modulo 2**CountWidth stays correct across counter wrap
  assign items = push_count - pop_count;

  // The pop count lags, so items can only be overstated and slots understated
  assign push_slots = CountWidth'(Depth) - items;

  assign full       = (push_slots == '0);
  assign push_ready = ~full;

endmodule

// ==== pop_side/cdc_fifo_pop_flag_mgr.sv ====
/*
 * Pop-side flag manager: beat handshake, binary pop count,
 * read address, registered Gray pop count, and items and empty
 */

`timescale 1ns/1ps

module cdc_fifo_pop_flag_mgr #(
  parameter int Depth      = 8,
  parameter int CountWidth = 4
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  pop_ready,
  output logic                  pop_valid,
  input  logic [CountWidth-1:0] push_count_gray_sync,
  output logic [CountWidth-1:0] pop_count_gray,
  output logic [CountWidth-2:0] rd_addr,
  output logic [CountWidth-1:0] pop_items
);

  localparam int AddrWidth = $clog2(Depth);

  logic                  pop_beat;
  logic                  empty;
  logic [CountWidth-1:0] pop_count;
  logic [CountWidth-1:0] pop_count_next;
  logic [CountWidth-1:0] push_count;

  // A beat is taken when a word is present and the sink accepts it
  assign pop_beat = pop_valid & pop_ready;

  assign pop_count_next = pop_count + CountWidth'(pop_beat);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_count <= '0;
    end else begin
      pop_count <= pop_count_next;
    end
  end

  // Registered Gray copy for the push side, updated on the beat edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_count_gray <= '0;
    end else begin
      pop_count_gray <= CountWidth'(cdc_fifo_pkg::bin_to_gray(16'(pop_count_next)));
    end
  end

  // The head entry is addressed by the low bits of the pop count
  assign rd_addr = pop_count[AddrWidth-1:0];

  // Decode the push count that has crossed the synchronizer
  assign push_count = CountWidth'(cdc_fifo_pkg::gray_to_bin(16'(push_count_gray_sync)));

  // Modular difference of the two counts
  // A push count that wrapped past the pop count still gives the right result
  // because both are reduced modulo 2**CountWidth
  assign pop_items = push_count - pop_count;

  // The push count arrives late, so items is never more than the true fill
  assign empty     = (pop_items == '0);
  assign pop_valid = ~empty;

endmodule

// ==== logic/cdc_fifo_storage.sv ====
/*
 * Register array for the dual-clock FIFO, written on the push clock
 * and read combinationally by the pop side
 */

`timescale 1ns/1ps

module cdc_fifo_storage #(
  parameter int Depth      = 8,
  parameter int DataWidth  = 16,
  parameter int CountWidth = 4
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [CountWidth-2:0] wr_addr,
  input  logic [DataWidth-1:0]  wr_data,
  input  logic [CountWidth-2:0] rd_addr,
  output logic [DataWidth-1:0]  rd_data
);

  // One word per entry
  // The address is CountWidth-1 bits wide, which covers Depth exactly
  logic [DataWidth-1:0] mem [Depth];

  // Words land on the push clock edge that takes the beat
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // The read path has no clock
  // An entry is only addressed by the pop side once the synchronized push
  // count has reported it, by which time the word has been stable for at
  // least two pop clock edges
  assign rd_data = mem[rd_addr];

endmodule

// ==== logic/cdc_fifo_top.sv ====
/*
 * Dual-clock FIFO top level: push and pop flag managers,
 * the register array, and one Gray count synchronizer per direction
 */

`timescale 1ns/1ps

module cdc_fifo_top #(
  parameter int  Depth      = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int  DataWidth  = cdc_fifo_pkg::DEFAULT_DATA_WIDTH,
  localparam int CountWidth = $clog2(Depth) + 1
) (
  input  logic                  push_clk,
  input  logic                  pop_clk,
  input  logic                  arst_n,
  input  logic                  push_valid,
  output logic                  push_ready,
  input  logic [DataWidth-1:0]  push_data,
  output logic [CountWidth-1:0] push_slots,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output logic [DataWidth-1:0]  pop_data,
  output logic [CountWidth-1:0] pop_items
);

  // Storage control from each side
  logic                  wr_en;
  logic [CountWidth-2:0] wr_addr;
  logic [CountWidth-2:0] rd_addr;

  // Gray counts before and after crossing
  logic [CountWidth-1:0] push_count_gray;
  logic [CountWidth-1:0] push_count_gray_sync;
  logic [CountWidth-1:0] pop_count_gray;
  logic [CountWidth-1:0] pop_count_gray_sync;

  // Push domain
  cdc_fifo_push_flag_mgr #(
    .Depth     (Depth),
    .CountWidth(CountWidth)
  ) i_push_flag_mgr (
    .clk                (push_clk),
    .arst_n             (arst_n),
    .push_valid         (push_valid),
    .push_ready         (push_ready),
    .pop_count_gray_sync(pop_count_gray_sync),
    .push_count_gray    (push_count_gray),
    .wr_en              (wr_en),
    .wr_addr            (wr_addr),
    .push_slots         (push_slots)
  );

  // Write port in the push domain, read port addressed from the pop domain
  // The incoming data goes straight to the array
  cdc_fifo_storage #(
    .Depth     (Depth),
    .DataWidth (DataWidth),
    .CountWidth(CountWidth)
  ) i_storage (
    .clk    (push_clk),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(push_data),
    .rd_addr(rd_addr),
    .rd_data(pop_data)
  );

  // Push count into the pop domain
  gray_count_sync #(
    .CountWidth(CountWidth)
  ) i_push_count_sync (
    .clk            (pop_clk),
    .arst_n         (arst_n),
    .count_gray     (push_count_gray),
    .count_gray_sync(push_count_gray_sync)
  );

  // Pop count into the push domain
  gray_count_sync #(
    .CountWidth(CountWidth)
  ) i_pop_count_sync (
    .clk            (push_clk),
    .arst_n         (arst_n),
    .count_gray     (pop_count_gray),
    .count_gray_sync(pop_count_gray_sync)
  );

  // Pop domain
  cdc_fifo_pop_flag_mgr #(
    .Depth     (Depth),
    .CountWidth(CountWidth)
  ) i_pop_flag_mgr (
    .clk                 (pop_clk),
    .arst_n              (arst_n),
    .pop_ready           (pop_ready),
    .pop_valid           (pop_valid),
    .push_count_gray_sync(push_count_gray_sync),
    .pop_count_gray      (pop_count_gray),
    .rd_addr             (rd_addr),
    .pop_items           (pop_items)
  );

endmodule

// ==== verification/cdc_fifo_tb.sv ====
/*
 * Testbench for the dual-clock FIFO: push and pop clocks, LFSR stimulus,
 * reference queue with compare process, flag bound checks and a timeout
 */

`timescale 1ns/1ps

module cdc_fifo_tb;

  localparam int depth       = cdc_fifo_pkg::DEFAULT_DEPTH;
  localparam int data_width  = cdc_fifo_pkg::DEFAULT_DATA_WIDTH;
  localparam int count_width = $clog2(depth) + 1;
  localparam int random_words = 300;
  // About 1000 push cycles for the whole sequence, so this leaves a wide margin
  localparam int timeout_cycles = 20000;

  logic                   push_clk;
  logic                   pop_clk;
  logic                   arst_n;
  logic                   push_valid;
  logic                   push_ready;
  logic [data_width-1:0]  push_data;
  logic [count_width-1:0] push_slots;
  logic                   pop_valid;
  logic                   pop_ready;
  logic [data_width-1:0]  pop_data;
  logic [count_width-1:0] pop_items;

  // Words accepted on the push side and not yet popped, oldest first
  logic [data_width-1:0] ref_q [$];
  logic [15:0]           lfsr_state;
  logic [data_width-1:0] hold_data;
  logic                  hold_valid;
  int pushes_seen;
  int pops_seen;
  int checks;
  int errors;
  int bound_errors;
  int hold_checks;
  int hold_errors;
  int err_mark;
  int tests_run;
  int tests_failed;
  int cycles;
  int mark;

  cdc_fifo_top #(
    .Depth    (depth),
    .DataWidth(data_width)
  ) i_cdc_fifo_top (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .arst_n    (arst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .push_slots(push_slots),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .pop_items (pop_items)
  );

  initial begin
    push_clk = 1'b0;
    forever #5 push_clk = ~push_clk;
  end

  // The 2.5 ns offset puts every pop clock edge on a half nanosecond,
  // so no edge of one clock ever meets an edge of the other
  initial begin
    pop_clk = 1'b0;
    #2.5;
    forever #8 pop_clk = ~pop_clk;
  end

  // Galois LFSR with taps 16, 14, 13, 11, one step per bit taken
  function automatic logic [15:0] take_bits(input int count);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[14:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  // Expected word for the next pop is the oldest accepted push
  function automatic logic [data_width-1:0] expected_head();
    return ref_q[0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $realtime, name, actual, expected);
    end
  endtask

  task automatic note_failure(input string text);
    errors++;
    $display("ERROR at %0t: %s", $realtime, text);
  endtask

  task automatic report_test(input string name, input int failures);
    tests_run++;
    if (failures == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", tests_run, name, failures);
    end
  endtask

  // A word stays on the bus until a beat takes it, then the next one may follow
  task automatic drive_pushes(input int count, input bit throttle);
    int goal;
    int seen;
    goal = pushes_seen + count;
    seen = pushes_seen;
    while (pushes_seen < goal) begin
      @(negedge push_clk);
      if (!push_valid || pushes_seen != seen) begin
        seen = pushes_seen;
        if (pushes_seen < goal && (!throttle || take_bits(1) == 16'd1)) begin
          push_valid = 1'b1;
          push_data  = take_bits(data_width);
        end else begin
          push_valid = 1'b0;
        end
      end
    end
  endtask

  task automatic drive_pops(input int count, input bit throttle);
    int goal;
    goal = pops_seen + count;
    while (pops_seen < goal) begin
      @(negedge pop_clk);
      if (pops_seen < goal && (!throttle || take_bits(1) == 16'd1)) begin
        pop_ready = 1'b1;
      end else begin
        pop_ready = 1'b0;
      end
    end
  endtask

  // Flags cross in two to three cycles, eight is plenty
  task automatic settle_items(input int value);
    int n;
    n = 0;
    do begin
      @(negedge pop_clk);
      n++;
    end while (int'(pop_items) != value && n < 8);
    check_value("pop_items", 32'(pop_items), value);
  endtask

  task automatic settle_slots(input int value);
    int n;
    n = 0;
    do begin
      @(negedge push_clk);
      n++;
    end while (int'(push_slots) != value && n < 8);
    check_value("push_slots", 32'(push_slots), value);
  endtask

  // Push monitor: slots may lag but must never promise room that is taken
  always @(posedge push_clk) begin
    if (arst_n) begin
      if (int'(push_slots) > depth - ref_q.size()) begin
        bound_errors++;
        note_failure($sformatf("push_slots %0d exceeds the %0d free entries",
                               push_slots, depth - ref_q.size()));
      end
      if (push_valid && push_ready) begin
        ref_q.push_back(push_data);
        pushes_seen++;
      end
    end
  end

  // Pop monitor: order check against the queue, bound check, hold check
  always @(posedge pop_clk) begin
    if (arst_n) begin
      if (int'(pop_items) > ref_q.size()) begin
        bound_errors++;
        note_failure($sformatf("pop_items %0d exceeds the %0d queued words",
                               pop_items, ref_q.size()));
      end
      if (hold_valid) begin
        hold_checks++;
        err_mark = errors;
        check_value("pop_valid", 32'(pop_valid), 1);
        check_value("pop_data", 32'(pop_data), 32'(hold_data));
        hold_errors += errors - err_mark;
      end
      hold_valid = pop_valid && !pop_ready;
      hold_data  = pop_data;
      if (pop_valid && pop_ready) begin
        if (ref_q.size() == 0) begin
          note_failure("a word was popped while the reference queue was empty");
        end else begin
          check_value("pop_data", 32'(pop_data), 32'(expected_head()));
          ref_q.delete(0);
        end
        pops_seen++;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge push_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d push clock cycles", timeout_cycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    // Times print in ns with one decimal, pop clock edges sit on half nanoseconds
    $timeformat(-9, 1, " ns", 0);
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    arst_n = 1'b0;
    lfsr_state = 16'd25;
    hold_valid = 1'b0;
    hold_data = '0;
    repeat (4) @(posedge push_clk);
    @(negedge push_clk);
    arst_n = 1'b1;

    mark = errors;
    @(negedge push_clk);
    check_value("push_ready", 32'(push_ready), 1);
    check_value("pop_valid", 32'(pop_valid), 0);
    check_value("push_slots", 32'(push_slots), depth);
    check_value("pop_items", 32'(pop_items), 0);
    report_test("reset state", errors - mark);

    // Fill with the pop side stalled, then offer one more word that must wait
    mark = errors;
    drive_pushes(depth, 1'b0);
    push_data = take_bits(data_width);
    push_valid = 1'b1;
    repeat (12) begin
      @(negedge push_clk);
      check_value("push_ready", 32'(push_ready), 0);
      check_value("push_slots", 32'(push_slots), 0);
    end
    push_valid = 1'b0;
    check_value("words accepted", pushes_seen, depth);
    settle_items(depth);
    report_test("fill", errors - mark);

    mark = errors;
    drive_pops(depth, 1'b0);
    check_value("pop_valid", 32'(pop_valid), 0);
    check_value("words popped", pops_seen, depth);
    check_value("queue length", ref_q.size(), 0);
    settle_slots(depth);
    report_test("drain", errors - mark);

    mark = errors;
    fork
      drive_pushes(random_words, 1'b1);
      drive_pops(random_words, 1'b1);
    join
    check_value("pop_valid", 32'(pop_valid), 0);
    check_value("queue length", ref_q.size(), 0);
    report_test("random traffic", errors - mark);

    report_test("flag bounds", bound_errors);
    if (hold_checks == 0) begin
      note_failure("no back-pressure cycle with pop_valid high was seen");
      hold_errors++;
    end
    report_test("back-pressure hold", hold_errors);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
common/cdc_fifo_pkg.sv
logic/gray_count_sync.sv
push_side/cdc_fifo_push_flag_mgr.sv
pop_side/cdc_fifo_pop_flag_mgr.sv
logic/cdc_fifo_storage.sv
logic/cdc_fifo_top.sv
verification/cdc_fifo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the dual-clock FIFO testbench with Verilator, runs it and
# decides the result from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
SIM_BIN=cdc_fifo_sim

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -sv \
  -f sources.f \
  --top-module cdc_fifo_tb \
  -Mdir "${BUILD_DIR}" \
  -o "${SIM_BIN}"
status=$?
if [ ${status} -ne 0 ]; then
  echo "Build failed with status ${status}"
  exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
status=$?
cat "${LOG_FILE}"
if [ ${status} -ne 0 ]; then
  echo "Simulation exited with status ${status}"
  exit 1
fi

if grep -q "Verification failed" "${LOG_FILE}"; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0
